// File: Bender.yml
package:
  name: tomasulo_slice

sources:
  - tomasulo_pkg.sv
  - rename_issue.sv
  - reservation_station.sv
  - alu_unit.sv
  - mul_unit.sv
  - tomasulo_core.sv
  - target: simulation
    files:
      - tb_checker.sv
      - tb_top.sv

// File: alu_unit.sv
`timescale 1ns/1ns

module alu_unit #(
  parameter int XLEN = 32
) (
  input  logic                      gsi,
  input  logic                      rst_n,
  input  tomasulo_pkg::dispatch_t   dispatch,
  output tomasulo_pkg::cdb_t        cdb
);

  logic [XLEN-1:0]          a;
  logic [XLEN-1:0]          b;
  logic [XLEN-1:0]          result;
  logic                     lane_valid;
  tomasulo_pkg::tag_t       lane_tag;
  tomasulo_pkg::reg_idx_t   lane_rd;
  logic [XLEN-1:0]          lane_value;

  assign a = dispatch.operand_a;
  assign b = dispatch.operand_b;

  always_comb begin
    case (dispatch.opcode)
      tomasulo_pkg::op_add: result = a + b;
      tomasulo_pkg::op_sub: result = a - b;
      tomasulo_pkg::op_and: result = a & b;
      tomasulo_pkg::op_xor: result = a ^ b;
      default:              result = '0;
    endcase
  end

  always_ff @(posedge gsi) begin
    if (!rst_n) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= dispatch.valid && dispatch.opcode != tomasulo_pkg::op_mul;
    end
  end

  always_ff @(posedge gsi) begin
    lane_tag   <= dispatch.tag;
    lane_rd    <= dispatch.rd;
    lane_value <= result;
  end

  assign cdb = '{valid: lane_valid, tag: lane_tag, rd: lane_rd, value: lane_value};

endmodule

// File: mul_unit.sv
`timescale 1ns/1ns

module mul_unit #(
  parameter int XLEN = 32
) (
  input  logic                      gsi,
  input  logic                      rst_n,
  input  tomasulo_pkg::dispatch_t   dispatch,
  output tomasulo_pkg::cdb_t        cdb
);

  localparam int half = XLEN / 2;

  logic [half-1:0]          a_lo;
  logic [half-1:0]          a_hi;
  logic [half-1:0]          b_lo;
  logic [XLEN-1:0]          b;
  logic                     s1_valid;
  tomasulo_pkg::tag_t       s1_tag;
  tomasulo_pkg::reg_idx_t   s1_rd;
  logic [XLEN-1:0]          s1_p_lo;   // a_lo * b
  logic [half-1:0]          s1_p_hi;   // a_hi * b_lo, upper bits fall off
  logic                     s2_valid;
  tomasulo_pkg::tag_t       s2_tag;
  tomasulo_pkg::reg_idx_t   s2_rd;
  logic [XLEN-1:0]          s2_value;

  assign a_lo = dispatch.operand_a[half-1:0];
  assign a_hi = dispatch.operand_a[XLEN-1:half];
  assign b    = dispatch.operand_b;
  assign b_lo = b[half-1:0];

  always_ff @(posedge gsi) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= dispatch.valid && dispatch.opcode == tomasulo_pkg::op_mul;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge gsi) begin
    s1_tag   <= dispatch.tag;
    s1_rd    <= dispatch.rd;
    s1_p_lo  <= XLEN'(a_lo * b);
    s1_p_hi  <= half'(a_hi * b_lo);
    s2_tag   <= s1_tag;
    s2_rd    <= s1_rd;
    s2_value <= s1_p_lo + {s1_p_hi, {half{1'b0}}};   // Low XLEN bits of the product
  end

  assign cdb = '{valid: s2_valid, tag: s2_tag, rd: s2_rd, value: s2_value};

  // Every operation the station hands over must be a multiply
  a_mul_origin: assert property (@(posedge gsi) disable iff (!rst_n)
    dispatch.valid |-> dispatch.opcode == tomasulo_pkg::op_mul);

endmodule

// File: rename_issue.sv
`timescale 1ns/1ns

module rename_issue #(
  parameter int XLEN = 32
) (
  input  logic                                 gsi,
  input  logic                                 rst_n,
  input  tomasulo_pkg::issue_slot_t [1:0]      issue,
  input  tomasulo_pkg::cdb_t [1:0]             cdb,
  input  logic [tomasulo_pkg::free_w-1:0]      alu_free,
  input  logic [tomasulo_pkg::free_w-1:0]      mul_free,
  output tomasulo_pkg::rs_insert_t             alu_insert,
  output tomasulo_pkg::rs_insert_t             mul_insert,
  output logic                                 ready,
  input  tomasulo_pkg::reg_idx_t               reg_addr,
  output logic [XLEN-1:0]                      reg_data
);

  if (XLEN != tomasulo_pkg::data_w) begin : g_xlen_check
    $fatal(1, "XLEN must match the package data width");
  end

  logic [XLEN-1:0]                      rf_value [tomasulo_pkg::arch_regs];
  tomasulo_pkg::tag_t                   rf_tag   [tomasulo_pkg::arch_regs];
  logic [tomasulo_pkg::arch_regs-1:0]   rf_busy;
  tomasulo_pkg::tag_t                   tag_q;   // Next tag to hand out
  tomasulo_pkg::tag_t                   slot_tag [2];
  tomasulo_pkg::rs_entry_t              slot_entry [2];

  // Source lookup; older_hit means slot 0 of this cycle writes the register
  function automatic tomasulo_pkg::operand_t lookup(tomasulo_pkg::reg_idx_t src,
                                                    logic older_hit,
                                                    tomasulo_pkg::tag_t older_tag);
    tomasulo_pkg::operand_t op;
    op.value = rf_value[src];
    op.tag   = rf_tag[src];
    op.ready = !rf_busy[src];
    if (older_hit) begin
      op.value = '0;
      op.tag   = older_tag;
      op.ready = 1'b0;
    end else if (rf_busy[src]) begin
      for (int j = 0; j < 2; j++) begin
        if (cdb[j].valid && cdb[j].tag == rf_tag[src]) begin
          op.value = cdb[j].value;   // Result arrives this very cycle
          op.ready = 1'b1;
        end
      end
    end
    return op;
  endfunction

  always_comb begin
    slot_tag[0] = tag_q;
    slot_tag[1] = tag_q + tomasulo_pkg::tag_t'(issue[0].valid);
    for (int s = 0; s < 2; s++) begin
      slot_entry[s].opcode = issue[s].opcode;
      slot_entry[s].tag    = slot_tag[s];
      slot_entry[s].rd     = issue[s].rd;
      slot_entry[s].a = lookup(issue[s].rs1,
                               s == 1 && issue[0].valid && issue[0].rd == issue[s].rs1,
                               slot_tag[0]);
      slot_entry[s].b = lookup(issue[s].rs2,
                               s == 1 && issue[0].valid && issue[0].rd == issue[s].rs2,
                               slot_tag[0]);
    end
  end

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      alu_insert.entry[s] = slot_entry[s];
      mul_insert.entry[s] = slot_entry[s];
      alu_insert.valid[s] = issue[s].valid &&
          (tomasulo_pkg::station_of(issue[s].opcode) == tomasulo_pkg::st_alu);
      mul_insert.valid[s] = issue[s].valid &&
          (tomasulo_pkg::station_of(issue[s].opcode) == tomasulo_pkg::st_mul);
    end
  end

  assign ready    = (alu_free >= 2) && (mul_free >= 2);
  assign reg_data = rf_value[reg_addr];

  always_ff @(posedge gsi) begin
    if (!rst_n) begin
      for (int i = 0; i < tomasulo_pkg::arch_regs; i++) begin
        rf_value[i] <= XLEN'(i);
        rf_tag[i]   <= '0;
      end
      rf_busy <= '0;
      tag_q   <= '0;
    end else begin
      for (int j = 0; j < 2; j++) begin
        // Only the newest producer of a register may retire into it
        if (cdb[j].valid && rf_busy[cdb[j].rd] && rf_tag[cdb[j].rd] == cdb[j].tag) begin
          rf_value[cdb[j].rd] <= cdb[j].value;
          rf_busy[cdb[j].rd]  <= 1'b0;
        end
      end
      for (int s = 0; s < 2; s++) begin
        if (issue[s].valid) begin
          rf_busy[issue[s].rd] <= 1'b1;
          rf_tag[issue[s].rd]  <= slot_tag[s];   // Slot 1 lands last and wins
        end
      end
      tag_q <= tag_q + tomasulo_pkg::tag_t'(issue[0].valid)
                     + tomasulo_pkg::tag_t'(issue[1].valid);
    end
  end

  // Tags in flight are unique so the two units never broadcast the same one
  a_lane_tags_unique: assert property (@(posedge gsi) disable iff (!rst_n)
    !(cdb[0].valid && cdb[1].valid && cdb[0].tag == cdb[1].tag));

endmodule

// File: reservation_station.sv
`timescale 1ns/1ns

module reservation_station #(
  parameter int                     XLEN    = 32,
  parameter int                     SIZE    = 8,
  parameter tomasulo_pkg::station_e ST_TYPE = tomasulo_pkg::st_alu
) (
  input  logic                                 gsi,
  input  logic                                 rst_n,
  input  tomasulo_pkg::rs_insert_t             insert,
  input  tomasulo_pkg::cdb_t [1:0]             cdb,
  output logic [tomasulo_pkg::free_w-1:0]      free_slots,
  output tomasulo_pkg::dispatch_t              dispatch
);

  localparam int idx_w = (SIZE > 1) ? $clog2(SIZE) : 1;

  tomasulo_pkg::rs_entry_t           entries     [SIZE];   // Index 0 is the oldest
  tomasulo_pkg::rs_entry_t           nxt_entries [SIZE];
  logic [tomasulo_pkg::free_w-1:0]   count;
  logic [tomasulo_pkg::free_w-1:0]   nxt_count;
  logic [1:0]                        accept;
  logic [1:0]                        ins_cnt;
  logic                              sel_found;
  logic [idx_w-1:0]                  sel_idx;
  logic [XLEN-1:0]                   sel_a;
  logic [XLEN-1:0]                   sel_b;
  logic                              disp_valid;
  tomasulo_pkg::opcode_e             disp_opcode;
  tomasulo_pkg::tag_t                disp_tag;
  tomasulo_pkg::reg_idx_t            disp_rd;
  logic [XLEN-1:0]                   disp_a;
  logic [XLEN-1:0]                   disp_b;

  function automatic tomasulo_pkg::operand_t capture(tomasulo_pkg::operand_t op,
                                                     tomasulo_pkg::cdb_t [1:0] bus);
    tomasulo_pkg::operand_t res;
    res = op;
    for (int j = 0; j < 2; j++) begin
      if (!op.ready && bus[j].valid && bus[j].tag == op.tag) begin
        res.value = bus[j].value;
        res.ready = 1'b1;
      end
    end
    return res;
  endfunction

  // True when a live entry still waits on tag t
  function automatic logic waits_on(tomasulo_pkg::tag_t t);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < SIZE; i++) begin
      if (i < int'(count)) begin
        hit |= (!entries[i].a.ready && entries[i].a.tag == t) ||
               (!entries[i].b.ready && entries[i].b.tag == t);
      end
    end
    return hit;
  endfunction

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      accept[s] = insert.valid[s] &&
                  (tomasulo_pkg::station_of(insert.entry[s].opcode) == ST_TYPE);
    end
  end

  assign ins_cnt    = 2'(accept[0]) + 2'(accept[1]);
  assign free_slots = tomasulo_pkg::free_w'(SIZE) - count;

  // Oldest entry with both operands already captured
  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = SIZE - 1; i >= 0; i--) begin
      if (i < int'(count) && entries[i].a.ready && entries[i].b.ready) begin
        sel_found = 1'b1;
        sel_idx   = idx_w'(i);
      end
    end
  end

  assign sel_a = entries[sel_idx].a.value;
  assign sel_b = entries[sel_idx].b.value;

  always_comb begin
    tomasulo_pkg::rs_entry_t cur;
    int src;
    int fill;
    for (int i = 0; i < SIZE; i++) begin
      src = (sel_found && i >= int'(sel_idx)) ? i + 1 : i;   // Close the gap
      if (src >= SIZE) begin
        src = SIZE - 1;
      end
      cur   = entries[src];
      cur.a = capture(cur.a, cdb);
      cur.b = capture(cur.b, cdb);
      nxt_entries[i] = cur;
    end
    fill = int'(count) - int'(sel_found);
    for (int s = 0; s < 2; s++) begin
      if (accept[s] && fill < SIZE) begin
        nxt_entries[fill] = insert.entry[s];
        fill++;
      end
    end
    nxt_count = count - tomasulo_pkg::free_w'(sel_found) + tomasulo_pkg::free_w'(ins_cnt);
  end

  always_ff @(posedge gsi) begin
    if (!rst_n) begin
      count      <= '0;
      disp_valid <= 1'b0;
    end else begin
      count      <= nxt_count;
      disp_valid <= sel_found;
    end
  end

  always_ff @(posedge gsi) begin
    entries     <= nxt_entries;
    disp_opcode <= entries[sel_idx].opcode;
    disp_tag    <= entries[sel_idx].tag;
    disp_rd     <= entries[sel_idx].rd;
    disp_a      <= sel_a;
    disp_b      <= sel_b;
  end

  assign dispatch = '{valid: disp_valid, opcode: disp_opcode, tag: disp_tag, rd: disp_rd,
                      operand_a: disp_a, operand_b: disp_b};

  // Rename keeps ready low until this station can take a whole pair
  a_no_overflow: assert property (@(posedge gsi) disable iff (!rst_n)
    ins_cnt <= free_slots);

  // An operand never keeps waiting on a tag the bus already carried
  a_capture_lane0: assert property (@(posedge gsi) disable iff (!rst_n)
    cdb[0].valid |=> !waits_on($past(cdb[0].tag)));

  a_capture_lane1: assert property (@(posedge gsi) disable iff (!rst_n)
    cdb[1].valid |=> !waits_on($past(cdb[1].tag)));

endmodule

// File: sources.f
tomasulo_pkg.sv
rename_issue.sv
reservation_station.sv
alu_unit.sv
mul_unit.sv
tomasulo_core.sv
tb_checker.sv
tb_top.sv

// File: tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
  input logic                            gsi,
  input logic                            rst_n,
  input tomasulo_pkg::cdb_t [1:0]        cdb,
  input logic [31:0]                     reg_data
);

  localparam int n_tags = 1 << tomasulo_pkg::tag_w;

  logic                   pend       [n_tags];   // Result still owed for this tag
  logic [31:0]            pend_value [n_tags];
  tomasulo_pkg::reg_idx_t pend_rd    [n_tags];
  string                  pend_test  [n_tags];
  int                     errors;
  int                     rec_count;
  int                     seen_count;

  initial begin
    errors     = 0;
    rec_count  = 0;
    seen_count = 0;
    for (int t = 0; t < n_tags; t++) begin
      pend[t] = 1'b0;
    end
  end

  // Called by the stimulus side in issue order
  task automatic add_record(input string test, input tomasulo_pkg::tag_t tag,
                            input tomasulo_pkg::reg_idx_t rd, input logic [31:0] value);
    if (pend[tag]) begin
      $display("ERROR: test %s hands out tag %0d while its previous result is still owed",
               test, tag);
      errors++;
    end
    pend[tag]       = 1'b1;
    pend_value[tag] = value;
    pend_rd[tag]    = rd;
    pend_test[tag]  = test;
    rec_count++;
  endtask

  task automatic check_broadcast(input int lane, input tomasulo_pkg::cdb_t c);
    if (!pend[c.tag]) begin
      $display("ERROR: bus lane %0d carried tag %0d with no outstanding record (repeat or stray)",
               lane, c.tag);
      errors++;
    end else begin
      pend[c.tag] = 1'b0;
      seen_count++;
      if (c.value !== pend_value[c.tag]) begin
        $display("MISMATCH test=%s tag=%0d value expected=%h actual=%h",
                 pend_test[c.tag], c.tag, pend_value[c.tag], c.value);
        errors++;
      end
      if (c.rd !== pend_rd[c.tag]) begin
        $display("MISMATCH test=%s tag=%0d rd expected=%0d actual=%0d",
                 pend_test[c.tag], c.tag, pend_rd[c.tag], c.rd);
        errors++;
      end
    end
  endtask

  // Lanes are registered, so mid-cycle each broadcast is seen exactly once
  always @(negedge gsi) begin
    if (rst_n) begin
      for (int j = 0; j < 2; j++) begin
        if (cdb[j].valid) begin
          check_broadcast(j, cdb[j]);
        end
      end
    end
  end

  task automatic check_reg(input string test, input int idx, input logic [31:0] expected);
    if (reg_data !== expected) begin
      $display("MISMATCH test=%s reg=%0d expected=%h actual=%h", test, idx, expected, reg_data);
      errors++;
    end
  endtask

  task automatic report_missing();
    for (int t = 0; t < n_tags; t++) begin
      if (pend[t]) begin
        $display("ERROR: test %s tag %0d was never broadcast on the bus", pend_test[t], t);
        errors++;
      end
    end
  endtask

endmodule

// File: tb_top.sv
`timescale 1ns/1ns

module tb_top;

  localparam int clk_period = 40;
  localparam int n_indep    = 40;
  localparam int n_chain    = 50;
  localparam int n_bp       = 60;
  localparam int watchdog_cycles = 200 + 12 * (n_indep + n_chain + n_bp);

  logic                            gsi;
  logic                            rst_n;
  tomasulo_pkg::issue_slot_t [1:0] issue;
  logic                            ready;
  tomasulo_pkg::cdb_t [1:0]        cdb;
  tomasulo_pkg::reg_idx_t          reg_addr;
  logic [31:0]                     reg_data;

  logic [31:0]        lfsr;
  logic [31:0]        model_rf [16];   // In-order architectural state
  tomasulo_pkg::tag_t model_tag;
  logic               ready_low_seen;
  int                 tb_errors;
  int                 errors_at_start;
  int                 pass_count;
  int                 fail_count;

  tomasulo_core #(.XLEN(32), .ALU_SIZE(8), .MUL_SIZE(4)) UUT (
    .gsi      (gsi),
    .rst_n    (rst_n),
    .issue    (issue),
    .ready    (ready),
    .cdb      (cdb),
    .reg_addr (reg_addr),
    .reg_data (reg_data)
  );

  tb_checker chk (
    .gsi      (gsi),
    .rst_n    (rst_n),
    .cdb      (cdb),
    .reg_data (reg_data)
  );

  initial begin
    gsi = 1'b0;
    forever #(clk_period / 2) gsi = ~gsi;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;
    end
    return n;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] expected_result(input tomasulo_pkg::opcode_e op,
                                                  input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (op)
      tomasulo_pkg::op_add: r = a + b;
      tomasulo_pkg::op_sub: r = a - b;
      tomasulo_pkg::op_and: r = a & b;
      tomasulo_pkg::op_xor: r = a ^ b;
      tomasulo_pkg::op_mul: r = a * b;   // Low 32 bits
      default:              r = '0;
    endcase
    return r;
  endfunction

  // Mode 0 independent ALU, 1 random chains, 2 mul-heavy back-pressure
  task automatic make_slot(input int mode, input tomasulo_pkg::reg_idx_t prev_rd,
                           output tomasulo_pkg::issue_slot_t slot);
    logic [31:0] r;
    slot = '0;
    if (mode == 2) begin
      slot.valid = 1'b1;
    end else begin
      take_bits(1, r);
      slot.valid = r[0];
    end
    case (mode)
      0: begin
        take_bits(2, r);
        slot.opcode = tomasulo_pkg::opcode_e'({1'b0, r[1:0]});
        take_bits(3, r);
        slot.rd = {1'b1, r[2:0]};   // Writes only 8..15, reads only 0..7
        take_bits(3, r);
        slot.rs1 = {1'b0, r[2:0]};
        take_bits(3, r);
        slot.rs2 = {1'b0, r[2:0]};
        if (slot.rs2 == slot.rs1) begin
          slot.rs2[0] = ~slot.rs2[0];
        end
      end
      1: begin
        take_bits(3, r);
        slot.opcode = tomasulo_pkg::opcode_e'(r % 5);
        take_bits(4, r);
        slot.rd = r[3:0];
        take_bits(4, r);
        slot.rs1 = r[3:0];
        take_bits(4, r);
        slot.rs2 = r[3:0];
        take_bits(1, r);
        if (r[0]) begin
          slot.rs1 = prev_rd;
        end
      end
      default: begin
        take_bits(2, r);
        if (r[1:0] != 2'd0) begin
          slot.opcode = tomasulo_pkg::op_mul;
        end else begin
          take_bits(2, r);
          slot.opcode = tomasulo_pkg::opcode_e'({1'b0, r[1:0]});
        end
        take_bits(4, r);
        slot.rd  = r[3:0];
        slot.rs1 = prev_rd;   // Serial chain keeps the stations full
        take_bits(4, r);
        slot.rs2 = r[3:0];
      end
    endcase
  endtask

  task automatic model_issue(input string name, input tomasulo_pkg::issue_slot_t slot);
    logic [31:0] v;
    v = expected_result(slot.opcode, model_rf[slot.rs1], model_rf[slot.rs2]);
    model_rf[slot.rd] = v;
    chk.add_record(name, model_tag, slot.rd, v);
    model_tag = model_tag + 1'b1;
  endtask

  task automatic run_stream(input int mode, input string name, input int total);
    int                        issued;
    tomasulo_pkg::issue_slot_t slot;
    tomasulo_pkg::reg_idx_t    prev_rd;
    issued  = 0;
    prev_rd = '0;
    while (issued < total) begin
      @(negedge gsi);
      issue = '0;
      if (!ready) begin
        ready_low_seen = 1'b1;
      end else begin
        for (int s = 0; s < 2; s++) begin
          make_slot(mode, prev_rd, slot);
          if (slot.valid && issued < total) begin
            issue[s] = slot;
            model_issue(name, slot);
            prev_rd = slot.rd;
            issued++;
          end
        end
      end
    end
    @(negedge gsi);
    issue = '0;
  endtask

  task automatic wait_drain();
    while (chk.seen_count != chk.rec_count) begin
      @(negedge gsi);
    end
  endtask

  task automatic read_all_regs(input string name);
    for (int i = 0; i < 16; i++) begin
      reg_addr = tomasulo_pkg::reg_idx_t'(i);
      @(negedge gsi);
      chk.check_reg(name, i, model_rf[i]);
    end
  endtask

  task automatic finish_test(input string name);
    int now_errors;
    now_errors = tb_errors + chk.errors;
    if (now_errors == errors_at_start) begin
      pass_count++;
      $display("Test %-16s PASS", name);
    end else begin
      fail_count++;
      $display("Test %-16s FAIL with %0d errors", name, now_errors - errors_at_start);
    end
    errors_at_start = now_errors;
  endtask

  initial begin
    #(watchdog_cycles * clk_period);
    $display("ERROR: run did not finish within %0d cycles", watchdog_cycles);
    chk.report_missing();
    $display("Regression failed");
    $finish;
  end

  initial begin
    issue           = '0;
    reg_addr        = '0;
    rst_n           = 1'b0;
    lfsr            = 32'd19;
    model_tag       = '0;
    ready_low_seen  = 1'b0;
    tb_errors       = 0;
    errors_at_start = 0;
    pass_count      = 0;
    fail_count      = 0;
    for (int i = 0; i < 16; i++) begin
      model_rf[i] = i;
    end
    repeat (3) @(posedge gsi);
    @(negedge gsi);
    rst_n = 1'b1;

    @(negedge gsi);
    if (ready !== 1'b1) begin
      $display("ERROR: ready is not high after reset");
      tb_errors++;
    end
    if (cdb[0].valid !== 1'b0 || cdb[1].valid !== 1'b0) begin
      $display("ERROR: a bus lane is valid right after reset");
      tb_errors++;
    end
    read_all_regs("reset_state");
    finish_test("reset_state");

    run_stream(0, "independent_alu", n_indep);
    wait_drain();
    finish_test("independent_alu");

    run_stream(1, "dependent_chains", n_chain);
    wait_drain();
    finish_test("dependent_chains");

    ready_low_seen = 1'b0;
    run_stream(2, "back_pressure", n_bp);
    wait_drain();
    if (!ready_low_seen) begin
      $display("ERROR: ready never went low during the back-pressure test");
      tb_errors++;
    end
    finish_test("back_pressure");

    read_all_regs("arch_state");
    finish_test("arch_state");

    $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0 && tb_errors + chk.errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: tomasulo_core.sv
`timescale 1ns/1ns

module tomasulo_core #(
  parameter int XLEN     = 32,
  parameter int ALU_SIZE = 8,
  parameter int MUL_SIZE = 4
) (
  input  logic                              gsi,
  input  logic                              rst_n,
  input  tomasulo_pkg::issue_slot_t [1:0]   issue,
  output logic                              ready,
  output tomasulo_pkg::cdb_t [1:0]          cdb,
  input  tomasulo_pkg::reg_idx_t            reg_addr,
  output logic [XLEN-1:0]                   reg_data
);

  tomasulo_pkg::rs_insert_t          alu_insert;
  tomasulo_pkg::rs_insert_t          mul_insert;
  logic [tomasulo_pkg::free_w-1:0]   alu_free;
  logic [tomasulo_pkg::free_w-1:0]   mul_free;
  tomasulo_pkg::dispatch_t           alu_disp;
  tomasulo_pkg::dispatch_t           mul_disp;

  rename_issue #(.XLEN(XLEN)) u_rename (
    .gsi        (gsi),
    .rst_n      (rst_n),
    .issue      (issue),
    .cdb        (cdb),
    .alu_free   (alu_free),
    .mul_free   (mul_free),
    .alu_insert (alu_insert),
    .mul_insert (mul_insert),
    .ready      (ready),
    .reg_addr   (reg_addr),
    .reg_data   (reg_data)
  );

  reservation_station #(
    .XLEN    (XLEN),
    .SIZE    (ALU_SIZE),
    .ST_TYPE (tomasulo_pkg::st_alu)
  ) u_alu_rs (
    .gsi        (gsi),
    .rst_n      (rst_n),
    .insert     (alu_insert),
    .cdb        (cdb),
    .free_slots (alu_free),
    .dispatch   (alu_disp)
  );

  reservation_station #(
    .XLEN    (XLEN),
    .SIZE    (MUL_SIZE),
    .ST_TYPE (tomasulo_pkg::st_mul)
  ) u_mul_rs (
    .gsi        (gsi),
    .rst_n      (rst_n),
    .insert     (mul_insert),
    .cdb        (cdb),
    .free_slots (mul_free),
    .dispatch   (mul_disp)
  );

  // Each unit owns one lane of the bus
  alu_unit #(.XLEN(XLEN)) u_alu (
    .gsi      (gsi),
    .rst_n    (rst_n),
    .dispatch (alu_disp),
    .cdb      (cdb[0])
  );

  mul_unit #(.XLEN(XLEN)) u_mul (
    .gsi      (gsi),
    .rst_n    (rst_n),
    .dispatch (mul_disp),
    .cdb      (cdb[1])
  );

endmodule

// File: tomasulo_pkg.sv
package tomasulo_pkg;

  localparam int tag_w     = 6;
  localparam int data_w    = 32;
  localparam int arch_regs = 16;
  localparam int free_w    = 5;   // Enough for 0 to 16 free entries

  typedef logic [tag_w-1:0] tag_t;
  typedef logic [3:0]       reg_idx_t;

  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_xor = 3'd3,
    op_mul = 3'd4
  } opcode_e;

  typedef enum logic {
    st_alu = 1'b0,
    st_mul = 1'b1
  } station_e;

  typedef struct packed {
    logic     valid;
    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
  } issue_slot_t;

  // Source operand as held in a station entry
  typedef struct packed {
    logic [data_w-1:0] value;
    tag_t              tag;     // Producer tag while not ready
    logic              ready;
  } operand_t;

  typedef struct packed {
    opcode_e  opcode;
    tag_t     tag;
    reg_idx_t rd;
    operand_t a;
    operand_t b;
  } rs_entry_t;

  // Both slots of one issue cycle, slot 0 older
  typedef struct packed {
    logic [1:0]      valid;
    rs_entry_t [1:0] entry;
  } rs_insert_t;

  typedef struct packed {
    logic              valid;
    opcode_e           opcode;
    tag_t              tag;
    reg_idx_t          rd;
    logic [data_w-1:0] operand_a;
    logic [data_w-1:0] operand_b;
  } dispatch_t;

  typedef struct packed {
    logic              valid;
    tag_t              tag;
    reg_idx_t          rd;
    logic [data_w-1:0] value;
  } cdb_t;

  function automatic station_e station_of(opcode_e op);
    return (op == op_mul) ? st_mul : st_alu;
  endfunction

endpackage
